//--- hw/ttop_pkg.sv
package ttop_pkg;

    ////////////////////
    // Widths and counts
    ////////////////////

    localparam int SAMPLE_BITS      = 14;
    localparam int SAMPLES_PER_WORD = 4;
    localparam int WDIS_BITS        = 3;
    localparam int CAP_WORDS        = 8;
    localparam int SLOT_BITS        = $clog2(SAMPLES_PER_WORD);
    localparam int WORD_CNT_BITS    = $clog2(CAP_WORDS);

    ////////////////////
    // Vector types
    ////////////////////

    typedef logic [SAMPLE_BITS-1:0]   sample_t;
    typedef logic [WDIS_BITS-1:0]     wdis_t;
    typedef logic [31:0]              pulse_width_t;
    typedef logic [SLOT_BITS-1:0]     slot_cnt_t;
    typedef logic [WORD_CNT_BITS-1:0] word_cnt_t;

    ////////////////////
    // Bundles
    ////////////////////

    // Slot 0 holds the oldest sample
    typedef struct packed {
        logic                           of;
        sample_t [SAMPLES_PER_WORD-1:0] samples;
    } merge_word_t;

    // Capture mode shot settings
    typedef struct packed {
        wdis_t        code;
        pulse_width_t width;
    } laser_cfg_t;

    typedef enum logic {
        ST_IDLE,
        ST_CAPTURE
    } cap_state_e;

endpackage

//--- hw/adc_sample_merge.sv
module adc_sample_merge
    import ttop_pkg::*;
(
    input  logic        clk200,
    input  logic        rst_n,
    input  sample_t     adc_data,
    input  logic        adc_of,
    input  logic        cap_window,
    output merge_word_t merge_data,
    output logic        merge_datv
);

    sample_t [SAMPLES_PER_WORD-1:0] slot_reg;
    slot_cnt_t                      slot_cnt;
    logic                           slot_last;
    logic                           of_acc;
    logic                           word_full;

    assign slot_last = (slot_cnt == slot_cnt_t'(SAMPLES_PER_WORD - 1));

    // Slot count restarts whenever the window is closed
    always_ff @(posedge clk200) begin
        if (!rst_n) begin
            slot_cnt  <= '0;
            word_full <= 1'b0;
        end else if (cap_window) begin
            if (slot_last) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 1'b1;
            end
            word_full <= slot_last;
        end else begin
            slot_cnt  <= '0;
            word_full <= 1'b0;
        end
    end

    // Newest sample enters at the top slot
    always_ff @(posedge clk200) begin
        if (cap_window) begin
            slot_reg <= {adc_data, slot_reg[SAMPLES_PER_WORD-1:1]};
            if (slot_cnt == '0) begin
                of_acc <= adc_of;
            end else begin
                of_acc <= of_acc | adc_of;
            end
        end
    end

    ////////////////////
    // Word output
    ////////////////////

    always_ff @(posedge clk200) begin
        if (!rst_n) begin
            merge_datv <= 1'b0;
        end else begin
            merge_datv <= word_full;
        end
    end

    // Slots are read before the next word overwrites them
    always_ff @(posedge clk200) begin
        if (word_full) begin
            merge_data.samples <= slot_reg;
            merge_data.of      <= of_acc;
        end
    end

endmodule

//--- hw/capture_ctrl.sv
module capture_ctrl
    import ttop_pkg::*;
(
    input  logic       clk200,
    input  logic       rst_n,
    input  logic       cap_mode,
    input  logic       cap_trig,
    input  laser_cfg_t cap_cfg,
    input  wdis_t      com_wdis,
    input  logic       com_open,
    input  logic       com_close,
    input  logic       word_valid,
    output logic       fire,
    output wdis_t      pulse_code,
    output logic       manual_on,
    output wdis_t      manual_code,
    output logic       cap_window,
    output logic       capr_rdy
);

    cap_state_e state;
    word_cnt_t  word_cnt;
    logic       trig_ok;
    logic       last_word;

    // Only an idle capture-mode trigger starts a shot
    assign trig_ok   = (state == ST_IDLE) && cap_mode && cap_trig;
    assign last_word = (state == ST_CAPTURE) && word_valid
                       && (word_cnt == word_cnt_t'(CAP_WORDS - 1));

    ////////////////////
    // Capture FSM
    ////////////////////

    always_ff @(posedge clk200) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            word_cnt   <= '0;
            fire       <= 1'b0;
            cap_window <= 1'b0;
            capr_rdy   <= 1'b0;
        end else begin
            fire     <= trig_ok;
            capr_rdy <= last_word;
            case (state)
                ST_IDLE: begin
                    word_cnt <= '0;
                    if (trig_ok) begin
                        state      <= ST_CAPTURE;
                        cap_window <= 1'b1;
                    end
                end
                ST_CAPTURE: begin
                    // Mode changes do not end a running capture
                    if (word_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                    if (last_word) begin
                        state      <= ST_IDLE;
                        cap_window <= 1'b0;
                    end
                end
                default: begin
                    state      <= ST_IDLE;
                    cap_window <= 1'b0;
                end
            endcase
        end
    end

    // Drive code of the shot
    always_ff @(posedge clk200) begin
        if (trig_ok) begin
            pulse_code <= cap_cfg.code;
        end
    end

    ////////////////////
    // Command mode
    ////////////////////

    // Close wins over open
    always_ff @(posedge clk200) begin
        if (!rst_n) begin
            manual_on <= 1'b0;
        end else if (cap_mode || com_close) begin
            manual_on <= 1'b0;
        end else if (com_open) begin
            manual_on <= 1'b1;
        end
    end

    always_ff @(posedge clk200) begin
        if (!cap_mode && com_open && !com_close) begin
            manual_code <= com_wdis;
        end
    end

endmodule

//--- hw/laser_pulse_gen.sv
module laser_pulse_gen
    import ttop_pkg::*;
(
    input  logic         clk200,
    input  logic         rst_n,
    input  logic         fire,
    input  wdis_t        pulse_code,
    input  pulse_width_t pulse_width,
    input  logic         manual_on,
    input  wdis_t        manual_code,
    output wdis_t        ldd_wp
);

    pulse_width_t pulse_cnt;
    logic         pulse_on;

    // Pulse level for the next cycle
    always_comb begin
        if (fire) begin
            pulse_on = (pulse_width != '0);
        end else begin
            pulse_on = (pulse_cnt != '0);
        end
    end

    ////////////////////
    // Width counter
    ////////////////////

    // Holds the cycles left after the current one
    always_ff @(posedge clk200) begin
        if (!rst_n) begin
            pulse_cnt <= '0;
        end else if (fire) begin
            if (pulse_width == '0) begin
                pulse_cnt <= '0;
            end else begin
                pulse_cnt <= pulse_width - 1'b1;
            end
        end else if (pulse_cnt != '0) begin
            pulse_cnt <= pulse_cnt - 1'b1;
        end
    end

    ////////////////////
    // Drive output
    ////////////////////

    // Manual drive overrides a running shot
    always_ff @(posedge clk200) begin
        if (!rst_n) begin
            ldd_wp <= '0;
        end else if (manual_on) begin
            ldd_wp <= manual_code;
        end else if (pulse_on) begin
            ldd_wp <= pulse_code;
        end else begin
            ldd_wp <= '0;
        end
    end

endmodule

//--- hw/ttop.sv
module ttop
    import ttop_pkg::*;
(
    input  logic        clk200,
    input  logic        rst_n,
    input  sample_t     adc_data,
    input  logic        adc_of,
    input  logic        cap_mode,
    input  logic        cap_trig,
    input  laser_cfg_t  cap_cfg,
    input  wdis_t       com_wdis,
    input  logic        com_open,
    input  logic        com_close,
    output wdis_t       ldd_wp,
    output merge_word_t merge_data,
    output logic        merge_datv,
    output logic        capr_rdy
);

    logic  word_valid;
    logic  cap_window;
    logic  fire;
    wdis_t pulse_code;
    logic  manual_on;
    wdis_t manual_code;

    assign merge_datv = word_valid;

    ////////////////////
    // Sample input
    ////////////////////

    adc_sample_merge u_merge (
        .clk200     (clk200),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_of     (adc_of),
        .cap_window (cap_window),
        .merge_data (merge_data),
        .merge_datv (word_valid)
    );

    ////////////////////
    // Capture control
    ////////////////////

    capture_ctrl u_ctrl (
        .clk200      (clk200),
        .rst_n       (rst_n),
        .cap_mode    (cap_mode),
        .cap_trig    (cap_trig),
        .cap_cfg     (cap_cfg),
        .com_wdis    (com_wdis),
        .com_open    (com_open),
        .com_close   (com_close),
        .word_valid  (word_valid),
        .fire        (fire),
        .pulse_code  (pulse_code),
        .manual_on   (manual_on),
        .manual_code (manual_code),
        .cap_window  (cap_window),
        .capr_rdy    (capr_rdy)
    );

    ////////////////////
    // Laser drive
    ////////////////////

    laser_pulse_gen u_laser (
        .clk200      (clk200),
        .rst_n       (rst_n),
        .fire        (fire),
        .pulse_code  (pulse_code),
        .pulse_width (cap_cfg.width),
        .manual_on   (manual_on),
        .manual_code (manual_code),
        .ldd_wp      (ldd_wp)
    );

endmodule

//--- verification/ttop_chk.sv
module ttop_chk
    import ttop_pkg::*;
(
    input logic        clk200,
    input logic        rst_n,
    input sample_t     adc_data,
    input logic        adc_of,
    input logic        cap_mode,
    input logic        cap_trig,
    input laser_cfg_t  cap_cfg,
    input wdis_t       com_wdis,
    input logic        com_open,
    input logic        com_close,
    input wdis_t       ldd_wp,
    input merge_word_t merge_data,
    input logic        merge_datv,
    input logic        capr_rdy
);

    timeunit 1ns;
    timeprecision 1ps;

    sample_t [SAMPLES_PER_WORD:0] data_hist;
    logic [SAMPLES_PER_WORD:0]    of_hist;
    merge_word_t                  exp_word;
    logic                         in_cap;
    int                           words;
    logic                         trig_acc;
    logic                         last_word;
    logic                         rdy_exp;
    logic                         fire_d;
    wdis_t                        shot_code;
    pulse_width_t                 pulse_left;
    logic                         man_on;
    logic                         man_on_d;
    wdis_t                        man_code;
    wdis_t                        man_code_d;
    wdis_t                        wp_exp;
    int                           fail_reset = 0;
    int                           fail_word = 0;
    int                           fail_window = 0;
    int                           fail_ready = 0;
    int                           fail_drive = 0;

    ////////////////////
    // Ramp tracker
    ////////////////////

    // Index 0 holds the sample of the previous edge
    always_ff @(posedge clk200) begin
        data_hist <= {data_hist[SAMPLES_PER_WORD-1:0], adc_data};
        of_hist   <= {of_hist[SAMPLES_PER_WORD-1:0], adc_of};
    end

    // A word leaves two edges after its newest sample
    always_comb begin
        for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
            exp_word.samples[i] = data_hist[SAMPLES_PER_WORD-i];
        end
        exp_word.of = |of_hist[SAMPLES_PER_WORD:1];
    end

    ////////////////////
    // Word and width counters
    ////////////////////

    assign trig_acc  = !in_cap && cap_mode && cap_trig;
    assign last_word = in_cap && merge_datv && (words == CAP_WORDS - 1);

    always_ff @(posedge clk200) begin
        if (!rst_n) begin
            in_cap     <= 1'b0;
            words      <= 0;
            rdy_exp    <= 1'b0;
            fire_d     <= 1'b0;
            pulse_left <= '0;
            man_on     <= 1'b0;
            man_on_d   <= 1'b0;
        end else begin
            rdy_exp  <= last_word;
            fire_d   <= trig_acc;
            man_on_d <= man_on;
            if (trig_acc) begin
                in_cap <= 1'b1;
                words  <= 0;
            end else if (last_word) begin
                in_cap <= 1'b0;
            end else if (in_cap && merge_datv) begin
                words <= words + 1;
            end
            // Width is taken one edge after the trigger
            if (fire_d) begin
                pulse_left <= cap_cfg.width;
            end else if (pulse_left != '0) begin
                pulse_left <= pulse_left - 1'b1;
            end
            if (cap_mode || com_close) begin
                man_on <= 1'b0;
            end else if (com_open) begin
                man_on <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk200) begin
        man_code_d <= man_code;
        if (trig_acc) begin
            shot_code <= cap_cfg.code;
        end
        if (!cap_mode && com_open && !com_close) begin
            man_code <= com_wdis;
        end
    end

    assign wp_exp = man_on_d ? man_code_d : ((pulse_left != '0) ? shot_code : '0);

    ////////////////////
    // Assertions
    ////////////////////

    a_reset: assert property (@(posedge clk200)
        !rst_n |=> (ldd_wp == '0 && !merge_datv && !capr_rdy))
        else begin
            $error("Fail at %0t: outputs not cleared by reset", $time);
            fail_reset++;
        end

    a_word: assert property (@(posedge clk200) disable iff (!rst_n)
        merge_datv |-> merge_data == exp_word)
        else begin
            $error("Fail at %0t: merged word %h, expected %h", $time, merge_data, exp_word);
            fail_word++;
        end

    a_window: assert property (@(posedge clk200) disable iff (!rst_n)
        merge_datv |-> in_cap)
        else begin
            $error("Fail at %0t: merged word outside a capture", $time);
            fail_window++;
        end

    a_ready: assert property (@(posedge clk200) disable iff (!rst_n) capr_rdy == rdy_exp)
        else begin
            $error("Fail at %0t: capr_rdy %0b, expected %0b", $time, capr_rdy, rdy_exp);
            fail_ready++;
        end

    a_drive: assert property (@(posedge clk200) disable iff (!rst_n) ldd_wp == wp_exp)
        else begin
            $error("Fail at %0t: ldd_wp %0d, expected %0d", $time, ldd_wp, wp_exp);
            fail_drive++;
        end

endmodule

//--- verification/tb_ttop.sv
module tb_ttop
    import ttop_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk200 = 1'b0;
    logic        rst_n;
    sample_t     adc_data = '0;
    logic        adc_of = 1'b0;
    logic        cap_mode;
    logic        cap_trig;
    laser_cfg_t  cap_cfg;
    wdis_t       com_wdis;
    logic        com_open;
    logic        com_close;
    wdis_t       ldd_wp;
    merge_word_t merge_data;
    logic        merge_datv;
    logic        capr_rdy;
    int          timeouts;
    int          assert_fails;
    int          errors;

    ttop u_dut (
        .clk200     (clk200),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_of     (adc_of),
        .cap_mode   (cap_mode),
        .cap_trig   (cap_trig),
        .cap_cfg    (cap_cfg),
        .com_wdis   (com_wdis),
        .com_open   (com_open),
        .com_close  (com_close),
        .ldd_wp     (ldd_wp),
        .merge_data (merge_data),
        .merge_datv (merge_datv),
        .capr_rdy   (capr_rdy)
    );

    bind ttop ttop_chk u_chk (
        .clk200     (clk200),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_of     (adc_of),
        .cap_mode   (cap_mode),
        .cap_trig   (cap_trig),
        .cap_cfg    (cap_cfg),
        .com_wdis   (com_wdis),
        .com_open   (com_open),
        .com_close  (com_close),
        .ldd_wp     (ldd_wp),
        .merge_data (merge_data),
        .merge_datv (merge_datv),
        .capr_rdy   (capr_rdy)
    );

    always #20 clk200 = ~clk200;

    // Free-running ramp with overflow on a few chosen values
    always @(posedge clk200) begin
        #2;
        adc_data <= adc_data + 1'b1;
        adc_of   <= (adc_data[3:0] == 4'd8) || (adc_data[5:0] == 6'd33);
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic next_cycle();
        @(posedge clk200);
        #2;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    task automatic fire_trigger();
        cap_trig = 1'b1;
        next_cycle();
        cap_trig = 1'b0;
    endtask

    task automatic command_strobe(input logic open, input logic close);
        com_open  = open;
        com_close = close;
        next_cycle();
        com_open  = 1'b0;
        com_close = 1'b0;
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        while (!capr_rdy && n < limit) begin
            next_cycle();
            n++;
        end
        if (!capr_rdy) begin
            timeouts++;
            $display("Timeout at %0t: no capture ready pulse within %0d cycles", $time, limit);
        end
    endtask

    task automatic wait_drive(input logic active, input int limit);
        int n;
        n = 0;
        while (((ldd_wp != '0) != active) && n < limit) begin
            next_cycle();
            n++;
        end
        if ((ldd_wp != '0) != active) begin
            timeouts++;
            $display("Timeout at %0t: laser drive did not turn %s within %0d cycles",
                     $time, active ? "on" : "off", limit);
        end
    endtask

    task automatic run_capture(input wdis_t code, input pulse_width_t width);
        cap_cfg.code  = code;
        cap_cfg.width = width;
        fire_trigger();
        if (width != '0) begin
            wait_drive(1'b1, 4);
            wait_drive(1'b0, width + 4);
        end
        wait_ready(64);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        rst_n     = 1'b0;
        cap_mode  = 1'b1;
        cap_trig  = 1'b0;
        cap_cfg   = '0;
        com_wdis  = '0;
        com_open  = 1'b0;
        com_close = 1'b0;
        timeouts  = 0;
        void'($urandom(10));
        idle(5);
        rst_n = 1'b1;
        idle(4);

        for (int k = 0; k < 4; k++) begin
            run_capture(wdis_t'($urandom_range(7, 1)), $urandom_range(20, 1));
            idle(3);
        end
        run_capture(wdis_t'($urandom_range(7, 1)), '0);
        idle(3);

        // Retriggers while a capture runs
        cap_cfg.code  = wdis_t'($urandom_range(7, 1));
        cap_cfg.width = $urandom_range(20, 1);
        fire_trigger();
        idle(2);
        fire_trigger();
        idle(12);
        fire_trigger();
        wait_ready(64);
        idle(40);

        // Mode switch inside a capture and triggers in command mode
        fire_trigger();
        idle(4);
        cap_mode = 1'b0;
        wait_ready(64);
        idle(3);
        fire_trigger();
        idle(40);

        // Manual drive
        com_wdis = wdis_t'($urandom_range(7, 1));
        command_strobe(1'b1, 1'b0);
        wait_drive(1'b1, 4);
        idle(10);
        command_strobe(1'b0, 1'b1);
        wait_drive(1'b0, 4);
        command_strobe(1'b1, 1'b1);
        idle(6);
        com_wdis = wdis_t'($urandom_range(7, 1));
        command_strobe(1'b1, 1'b0);
        wait_drive(1'b1, 4);
        idle(5);
        cap_mode = 1'b1;
        wait_drive(1'b0, 4);
        command_strobe(1'b1, 1'b0);
        idle(6);

        assert_fails = u_dut.u_chk.fail_reset + u_dut.u_chk.fail_word
                     + u_dut.u_chk.fail_window + u_dut.u_chk.fail_ready
                     + u_dut.u_chk.fail_drive;
        errors = timeouts + assert_fails;
        $display("Errors: %0d (%0d timeouts, %0d assertion failures)",
                 errors, timeouts, assert_fails);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- build.f
hw/ttop_pkg.sv
hw/adc_sample_merge.sv
hw/capture_ctrl.sv
hw/laser_pulse_gen.sv
hw/ttop.sv
verification/ttop_chk.sv
verification/tb_ttop.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ttop -f build.f -Mdir obj_dir -o sim_tb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
    echo "FAIL: the testbench reported errors"
    exit 1
fi
if grep -q "%Error" "$SIM_LOG"; then
    echo "FAIL: assertion errors found in $SIM_LOG"
    exit 1
fi

echo "PASS"
exit 0
